// ==== source/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl #(
    parameter int LINE_COUNT = dcache_pkg::DEFAULT_LINE_COUNT,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  logic                          rd_i,
    input  logic                          we_i,
    input  logic                          fence_i,
    input  logic                          hit_i,
    input  logic                          dirty_i,
    input  logic [dcache_pkg::ADDR_W-$clog2(LINE_COUNT)-$clog2(LINE_BYTES)-1:0] stored_tag_i,
    input  logic [$clog2(LINE_COUNT)-1:0] flush_index_i,
    input  logic                          flush_pending_i,
    input  logic [LINE_BYTES*8-1:0]       line_i,
    input  logic [LINE_BYTES*8-1:0]       merged_i,
    input  logic [LINE_BYTES*8-1:0]       mem_rdata_i,
    input  logic                          mem_ack_i,
    output logic                          valid_o,
    output logic [$clog2(LINE_COUNT)-1:0] line_index_o,
    output logic                          ram_we_o,
    output logic [LINE_BYTES*8-1:0]       ram_wline_o,
    output logic                          fill_o,
    output logic                          mark_dirty_o,
    output logic                          clean_o,
    output logic [$clog2(LINE_COUNT)-1:0] clean_index_o,
    output logic                          invalidate_all_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [LINE_BYTES*8-1:0]       mem_wdata_o,
    output logic                          mem_rd_o,
    output logic                          mem_we_o
);

    import dcache_pkg::*;

    localparam int OFF_W    = $clog2(LINE_BYTES);
    localparam int IDX_W    = $clog2(LINE_COUNT);
    localparam int LADDR_W  = ADDR_W - OFF_W;

    cache_state_e       state_q;
    logic [LADDR_W-1:0] miss_line_q;
    logic [IDX_W-1:0]   req_index;
    logic [IDX_W-1:0]   miss_index;
    logic               access;

    assign req_index  = addr_i[OFF_W +: IDX_W];
    assign miss_index = miss_line_q[IDX_W-1:0];
    assign access     = rd_i | we_i;

    // The outstanding write-back names the line to clean.
    assign clean_index_o = mem_addr_o[OFF_W +: IDX_W];
    assign ram_wline_o   = (state_q == ST_FILL) ? mem_rdata_i : merged_i;

    // ####################################################################
    // Strobes and index select.
    // ####################################################################

    always_comb begin
        valid_o          = 1'b0;
        ram_we_o         = 1'b0;
        fill_o           = 1'b0;
        mark_dirty_o     = 1'b0;
        clean_o          = 1'b0;
        invalidate_all_o = 1'b0;
        line_index_o     = req_index;
        case (state_q)
            ST_IDLE: begin
                if (fence_i) begin
                    invalidate_all_o = 1'b1;
                end else if (access && hit_i) begin
                    valid_o      = 1'b1;
                    ram_we_o     = we_i;
                    mark_dirty_o = we_i;
                end
            end
            ST_WRITEBACK: begin
                line_index_o = miss_index;
                clean_o      = mem_ack_i;
            end
            ST_FILL: begin
                line_index_o = miss_index;
                ram_we_o     = mem_ack_i;
                fill_o       = mem_ack_i;
            end
            ST_FLUSH: begin
                line_index_o = flush_index_i;
                clean_o      = mem_we_o && mem_ack_i;
            end
            ST_FENCE_DONE: begin
                valid_o = 1'b1;
            end
            default: begin
                line_index_o = req_index;
            end
        endcase
    end

    // ####################################################################
    // State and memory requests.
    // ####################################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= ST_IDLE;
            mem_rd_o <= 1'b0;
            mem_we_o <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (fence_i) begin
                        state_q <= ST_FLUSH;
                    end else if (access && !hit_i) begin
                        if (dirty_i) begin
                            state_q  <= ST_WRITEBACK;
                            mem_we_o <= 1'b1;
                        end else begin
                            state_q  <= ST_FILL;
                            mem_rd_o <= 1'b1;
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (mem_ack_i) begin
                        state_q  <= ST_FILL;
                        mem_we_o <= 1'b0;
                        mem_rd_o <= 1'b1;
                    end
                end
                ST_FILL: begin
                    if (mem_ack_i) begin
                        state_q  <= ST_IDLE;
                        mem_rd_o <= 1'b0;
                    end
                end
                ST_FLUSH: begin
                    if (mem_we_o) begin
                        if (mem_ack_i) begin
                            mem_we_o <= 1'b0;
                        end
                    end else if (flush_pending_i) begin
                        mem_we_o <= 1'b1;
                    end else begin
                        state_q <= ST_FENCE_DONE;
                    end
                end
                ST_FENCE_DONE: begin
                    state_q <= ST_IDLE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Each request payload is loaded on the edge that raises its strobe.
    always_ff @(posedge clk) begin
        case (state_q)
            ST_IDLE: begin
                if (access) begin
                    miss_line_q <= addr_i[ADDR_W-1:OFF_W];
                    if (dirty_i) begin
                        mem_addr_o  <= {stored_tag_i, req_index, {OFF_W{1'b0}}};
                        mem_wdata_o <= line_i;
                    end else begin
                        mem_addr_o <= {addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
                    end
                end
            end
            ST_WRITEBACK: begin
                if (mem_ack_i) begin
                    mem_addr_o <= {miss_line_q, {OFF_W{1'b0}}};
                end
            end
            ST_FLUSH: begin
                if (!mem_we_o) begin
                    mem_addr_o  <= {stored_tag_i, flush_index_i, {OFF_W{1'b0}}};
                    mem_wdata_o <= line_i;
                end
            end
            default: begin
                mem_addr_o <= mem_addr_o;
            end
        endcase
    end

endmodule

// ==== source/dcache_line_merge.sv ====
`timescale 1ns/10ps

module dcache_line_merge #(
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  logic [LINE_BYTES*8-1:0]       line_i,
    input  logic [$clog2(LINE_BYTES)-1:0] offset_i,
    input  dcache_pkg::size_e             size_i,
    input  logic [dcache_pkg::WORD_W-1:0] wdata_i,
    output logic [dcache_pkg::WORD_W-1:0] rword_o,
    output logic [LINE_BYTES*8-1:0]       merged_o
);

    import dcache_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);

    logic [OFF_W-1:0] half_off;
    logic [OFF_W-1:0] word_off;

    // Byte offsets rounded down to the access alignment.
    assign half_off = {offset_i[OFF_W-1:1], 1'b0};
    assign word_off = {offset_i[OFF_W-1:2], 2'b00};

    // ####################################################################
    // Read word select.
    // ####################################################################

    assign rword_o = line_i[8*word_off +: WORD_W];

    // ####################################################################
    // Store merge.
    // ####################################################################

    always_comb begin
        merged_o = line_i;
        case (size_i)
            SIZE_BYTE: begin
                merged_o[8*offset_i +: 8] = wdata_i[7:0];
            end
            SIZE_HALF: begin
                merged_o[8*half_off +: 16] = wdata_i[15:0];
            end
            SIZE_WORD: begin
                merged_o[8*word_off +: WORD_W] = wdata_i;
            end
            default: begin
                // Unused encoding leaves the line as it is.
                merged_o = line_i;
            end
        endcase
    end

endmodule

// ==== source/dcache_line_ram.sv ====
`timescale 1ns/10ps

module dcache_line_ram #(
    parameter int LINE_COUNT = dcache_pkg::DEFAULT_LINE_COUNT,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  logic                          clk,
    input  logic [$clog2(LINE_COUNT)-1:0] index_i,
    input  logic                          we_i,
    input  logic [LINE_BYTES*8-1:0]       wline_i,
    output logic [LINE_BYTES*8-1:0]       rline_o
);

    localparam int LINE_W = LINE_BYTES * 8;

    // One entry per cache line.
    logic [LINE_W-1:0] lines_q [LINE_COUNT];

    always_ff @(posedge clk) begin
        if (we_i) begin
            lines_q[index_i] <= wline_i;
        end
    end

    // Distributed-RAM style read, visible in the same cycle.
    assign rline_o = lines_q[index_i];

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // Load/store side widths.
    parameter int ADDR_W = 32;
    parameter int WORD_W = 32;

    // Top-level geometry defaults that module parameters override.
    parameter int DEFAULT_LINE_COUNT = 64;
    parameter int DEFAULT_LINE_BYTES = 32;

    // ####################################################################
    // Encodings.
    // ####################################################################

    // Access size of a load or store.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    // Cache controller states.
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_WRITEBACK  = 3'd1,
        ST_FILL       = 3'd2,
        ST_FLUSH      = 3'd3,
        ST_FENCE_DONE = 3'd4
    } cache_state_e;

endpackage

// ==== source/dcache_tag_store.sv ====
`timescale 1ns/10ps

module dcache_tag_store #(
    parameter int LINE_COUNT = dcache_pkg::DEFAULT_LINE_COUNT,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [$clog2(LINE_COUNT)-1:0] index_i,
    input  logic [dcache_pkg::ADDR_W-$clog2(LINE_COUNT)-$clog2(LINE_BYTES)-1:0] tag_i,
    input  logic                          fill_i,
    input  logic                          mark_dirty_i,
    input  logic                          clean_i,
    input  logic [$clog2(LINE_COUNT)-1:0] clean_index_i,
    input  logic                          invalidate_all_i,
    output logic                          hit_o,
    output logic                          dirty_o,
    output logic [dcache_pkg::ADDR_W-$clog2(LINE_COUNT)-$clog2(LINE_BYTES)-1:0] tag_o,
    output logic [$clog2(LINE_COUNT)-1:0] flush_index_o,
    output logic                          flush_pending_o
);

    import dcache_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(LINE_COUNT);
    localparam int TAG_W = ADDR_W - IDX_W - OFF_W;

    logic [TAG_W-1:0]      tags_q [LINE_COUNT];
    logic [LINE_COUNT-1:0] valid_q;
    logic [LINE_COUNT-1:0] dirty_q;

    // ####################################################################
    // Line state.
    // ####################################################################

    always_ff @(posedge clk) begin
        if (fill_i) begin
            tags_q[index_i] <= tag_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (invalidate_all_i) begin
                valid_q <= '0;
            end
            if (fill_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end
            // A written-back line may differ from index_i during a fence.
            if (clean_i) begin
                dirty_q[clean_index_i] <= 1'b0;
            end
        end
    end

    // ####################################################################
    // Lookup and flush search.
    // ####################################################################

    assign tag_o   = tags_q[index_i];
    assign hit_o   = valid_q[index_i] && (tags_q[index_i] == tag_i);
    assign dirty_o = dirty_q[index_i];

    // Walk downwards so the lowest dirty index wins.
    always_comb begin
        flush_index_o = '0;
        for (int i = LINE_COUNT - 1; i >= 0; i--) begin
            if (dirty_q[i]) begin
                flush_index_o = IDX_W'(i);
            end
        end
    end

    assign flush_pending_o = |dirty_q;

endmodule

// ==== source/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top #(
    parameter int LINE_COUNT = dcache_pkg::DEFAULT_LINE_COUNT,
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::ADDR_W-1:0] addr_i,
    input  logic [dcache_pkg::WORD_W-1:0] wdata_i,
    input  dcache_pkg::size_e             size_i,
    input  logic                          rd_i,
    input  logic                          we_i,
    input  logic                          fence_i,
    output logic [dcache_pkg::WORD_W-1:0] rdata_o,
    output logic                          valid_o,
    output logic [dcache_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [LINE_BYTES*8-1:0]       mem_wdata_o,
    output logic                          mem_rd_o,
    output logic                          mem_we_o,
    input  logic [LINE_BYTES*8-1:0]       mem_rdata_i,
    input  logic                          mem_ack_i
);

    import dcache_pkg::*;

    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int IDX_W  = $clog2(LINE_COUNT);
    localparam int TAG_W  = ADDR_W - IDX_W - OFF_W;
    localparam int LINE_W = LINE_BYTES * 8;

    logic [OFF_W-1:0]  req_offset;
    logic [TAG_W-1:0]  req_tag;
    logic [IDX_W-1:0]  line_index;
    logic              ram_we;
    logic [LINE_W-1:0] ram_wline;
    logic [LINE_W-1:0] rline;
    logic [LINE_W-1:0] merged;
    logic              hit;
    logic              dirty;
    logic [TAG_W-1:0]  stored_tag;
    logic [IDX_W-1:0]  flush_index;
    logic              flush_pending;
    logic              fill;
    logic              mark_dirty;
    logic              clean;
    logic [IDX_W-1:0]  clean_index;
    logic              invalidate_all;

    // Index bits are taken by the controller directly from addr_i.
    assign req_offset = addr_i[OFF_W-1:0];
    assign req_tag    = addr_i[ADDR_W-1:OFF_W+IDX_W];

    dcache_line_ram #(
        .LINE_COUNT(LINE_COUNT),
        .LINE_BYTES(LINE_BYTES)
    ) i_line_ram (
        .clk     (clk),
        .index_i (line_index),
        .we_i    (ram_we),
        .wline_i (ram_wline),
        .rline_o (rline)
    );

    dcache_tag_store #(
        .LINE_COUNT(LINE_COUNT),
        .LINE_BYTES(LINE_BYTES)
    ) i_tag_store (
        .clk              (clk),
        .rst              (rst),
        .index_i          (line_index),
        .tag_i            (req_tag),
        .fill_i           (fill),
        .mark_dirty_i     (mark_dirty),
        .clean_i          (clean),
        .clean_index_i    (clean_index),
        .invalidate_all_i (invalidate_all),
        .hit_o            (hit),
        .dirty_o          (dirty),
        .tag_o            (stored_tag),
        .flush_index_o    (flush_index),
        .flush_pending_o  (flush_pending)
    );

    dcache_line_merge #(
        .LINE_BYTES(LINE_BYTES)
    ) i_line_merge (
        .line_i   (rline),
        .offset_i (req_offset),
        .size_i   (size_i),
        .wdata_i  (wdata_i),
        .rword_o  (rdata_o),
        .merged_o (merged)
    );

    dcache_ctrl #(
        .LINE_COUNT(LINE_COUNT),
        .LINE_BYTES(LINE_BYTES)
    ) i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .addr_i           (addr_i),
        .rd_i             (rd_i),
        .we_i             (we_i),
        .fence_i          (fence_i),
        .hit_i            (hit),
        .dirty_i          (dirty),
        .stored_tag_i     (stored_tag),
        .flush_index_i    (flush_index),
        .flush_pending_i  (flush_pending),
        .line_i           (rline),
        .merged_i         (merged),
        .mem_rdata_i      (mem_rdata_i),
        .mem_ack_i        (mem_ack_i),
        .valid_o          (valid_o),
        .line_index_o     (line_index),
        .ram_we_o         (ram_we),
        .ram_wline_o      (ram_wline),
        .fill_o           (fill),
        .mark_dirty_o     (mark_dirty),
        .clean_o          (clean),
        .clean_index_o    (clean_index),
        .invalidate_all_o (invalidate_all),
        .mem_addr_o       (mem_addr_o),
        .mem_wdata_o      (mem_wdata_o),
        .mem_rd_o         (mem_rd_o),
        .mem_we_o         (mem_we_o)
    );

endmodule

// ==== sources.f ====
source/dcache_pkg.sv
source/dcache_line_ram.sv
source/dcache_tag_store.sv
source/dcache_line_merge.sv
source/dcache_ctrl.sv
source/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// ==== verification/dcache_mem_model.sv ====
`timescale 1ns/10ps

module dcache_mem_model #(
    parameter int LINE_BYTES = dcache_pkg::DEFAULT_LINE_BYTES,
    parameter int MEM_BYTES  = 4096
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [dcache_pkg::ADDR_W-1:0] mem_addr_i,
    input  logic [LINE_BYTES*8-1:0]       mem_wdata_i,
    input  logic                          mem_rd_i,
    input  logic                          mem_we_i,
    output logic [LINE_BYTES*8-1:0]       mem_rdata_o,
    output logic                          mem_ack_o
);

    localparam int OFF_W  = $clog2(LINE_BYTES);
    localparam int LINES  = MEM_BYTES / LINE_BYTES;
    localparam int LSEL_W = $clog2(LINES);

    // Line contents, read directly by the testbench checker.
    logic [LINE_BYTES*8-1:0] lines [LINES];
    logic [LSEL_W-1:0]       line_sel;
    logic [1:0]              wait_q;
    logic                    busy_q;

    function automatic logic [7:0] fill_pattern(int a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    assign line_sel = mem_addr_i[OFF_W +: LSEL_W];

    initial begin
        for (int l = 0; l < LINES; l++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                lines[l][8*b +: 8] = fill_pattern(l * LINE_BYTES + b);
            end
        end
    end

    // Ack comes 1 to 4 cycles after the request is taken.
    always @(posedge clk) begin
        if (rst) begin
            mem_ack_o <= 1'b0;
            busy_q    <= 1'b0;
            wait_q    <= '0;
        end else begin
            mem_ack_o <= 1'b0;
            if (busy_q) begin
                if (wait_q == 0) begin
                    mem_ack_o <= 1'b1;
                    busy_q    <= 1'b0;
                    if (mem_we_i) begin
                        lines[line_sel] <= mem_wdata_i;
                    end else begin
                        mem_rdata_o <= lines[line_sel];
                    end
                end else begin
                    wait_q <= wait_q - 2'd1;
                end
            end else if ((mem_rd_i || mem_we_i) && !mem_ack_o) begin
                busy_q <= 1'b1;
                wait_q <= 2'($urandom_range(3, 0));
            end
        end
    end

endmodule

// ==== verification/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb;

    import dcache_pkg::*;

    localparam int LINE_COUNT = 64;
    localparam int LINE_BYTES = 32;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int MEM_BYTES  = 4096;
    localparam int MEM_LINES  = MEM_BYTES / LINE_BYTES;
    localparam int ROUNDS     = 3;
    localparam int OPS        = 300;
    // Two worst-case 6-cycle transfers per op, 64 cycles per line per fence, then margin.
    localparam int CYCLE_LIMIT = ROUNDS * OPS * 2 * 6 + ROUNDS * 64 * LINE_COUNT
                                 + ROUNDS * OPS * 4 + 500;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] wdata;
    size_e             size;
    logic              rd;
    logic              we;
    logic              fence;
    logic [WORD_W-1:0] rdata;
    logic              valid;
    logic [ADDR_W-1:0] mem_addr;
    logic [LINE_W-1:0] mem_wdata;
    logic              mem_rd;
    logic              mem_we;
    logic [LINE_W-1:0] mem_rdata;
    logic              mem_ack;

    // Reference model: flat byte image plus direct-mapped residency.
    logic [7:0] ref_mem [MEM_BYTES];
    logic       res_valid [LINE_COUNT];
    logic       res_dirty [LINE_COUNT];
    int         res_line [LINE_COUNT];
    int         checks = 0;
    int         errors = 0;
    int         cycles = 0;

    dcache_top #(
        .LINE_COUNT(LINE_COUNT),
        .LINE_BYTES(LINE_BYTES)
    ) i_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .addr_i      (addr),
        .wdata_i     (wdata),
        .size_i      (size),
        .rd_i        (rd),
        .we_i        (we),
        .fence_i     (fence),
        .rdata_o     (rdata),
        .valid_o     (valid),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rd_o    (mem_rd),
        .mem_we_o    (mem_we),
        .mem_rdata_i (mem_rdata),
        .mem_ack_i   (mem_ack)
    );

    dcache_mem_model #(
        .LINE_BYTES(LINE_BYTES),
        .MEM_BYTES (MEM_BYTES)
    ) i_mem (
        .clk         (clk),
        .rst         (rst),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_rd_i    (mem_rd),
        .mem_we_i    (mem_we),
        .mem_rdata_o (mem_rdata),
        .mem_ack_o   (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the cache gave no response within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ####################################################################
    // Model helpers and checks.
    // ####################################################################

    function automatic logic [7:0] initial_byte(int a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h5a;
    endfunction

    function automatic logic [LINE_W-1:0] model_line(int line);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < LINE_BYTES; b++) begin
            l[8*b +: 8] = ref_mem[line * LINE_BYTES + b];
        end
        return l;
    endfunction

    task automatic check_value(input string name, input logic [LINE_W-1:0] got,
                               input logic [LINE_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s at %0t: got %0h expected %0h", name, $time, got, exp);
        end
    endtask

    task automatic run_access(input logic write, input int a, input int sz,
                              input logic [WORD_W-1:0] data);
        int          line;
        int          idx;
        int          victim;
        int          base;
        int          nbytes;
        logic        resident;
        logic        evict;
        logic        saw_rd;
        logic        saw_we;
        logic [31:0] exp_word;
        line     = a / LINE_BYTES;
        idx      = line % LINE_COUNT;
        victim   = res_line[idx];
        resident = res_valid[idx] && (victim == line);
        evict    = !resident && res_valid[idx] && res_dirty[idx];
        saw_rd   = 1'b0;
        saw_we   = 1'b0;
        base     = a & ~3;
        exp_word = {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
        @(posedge clk);
        addr  <= a;
        wdata <= data;
        size  <= size_e'(sz);
        rd    <= !write;
        we    <= write;
        do begin
            @(negedge clk);
            if (mem_we && !saw_we) begin
                saw_we = 1'b1;
                if (evict) begin
                    check_value("mem_addr_o", mem_addr, victim * LINE_BYTES);
                    check_value("mem_wdata_o", mem_wdata, model_line(victim));
                end
            end
            if (mem_rd && !saw_rd) begin
                saw_rd = 1'b1;
                check_value("mem_addr_o", mem_addr, line * LINE_BYTES);
            end
        end while (!valid);
        if (!write) begin
            check_value("rdata_o", rdata, exp_word);
        end
        check_value("mem_we_o", saw_we, evict);
        check_value("mem_rd_o", saw_rd, !resident);
        @(posedge clk);
        rd <= 1'b0;
        we <= 1'b0;
        if (write) begin
            nbytes = (sz == 0) ? 1 : (sz == 1) ? 2 : 4;
            base   = a & ~(nbytes - 1);
            for (int b = 0; b < nbytes; b++) begin
                ref_mem[base + b] = data[8*b +: 8];
            end
        end
        if (!resident) begin
            res_dirty[idx] = 1'b0;
        end
        if (write) begin
            res_dirty[idx] = 1'b1;
        end
        res_valid[idx] = 1'b1;
        res_line[idx]  = line;
    endtask

    task automatic run_fence();
        logic saw_rd;
        saw_rd = 1'b0;
        @(posedge clk);
        fence <= 1'b1;
        do begin
            @(negedge clk);
            if (mem_rd) begin
                saw_rd = 1'b1;
            end
        end while (!valid);
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        // Done strobe lasts one cycle only.
        check_value("valid_o", valid, 1'b0);
        check_value("mem_rd_o", saw_rd, 1'b0);
        for (int l = 0; l < MEM_LINES; l++) begin
            check_value($sformatf("memory line %0d", l), i_mem.lines[l], model_line(l));
        end
        for (int i = 0; i < LINE_COUNT; i++) begin
            res_valid[i] = 1'b0;
            res_dirty[i] = 1'b0;
        end
    endtask

    // ####################################################################
    // Test sequence.
    // ####################################################################

    initial begin
        int          errs_before;
        logic        write;
        int          a;
        int          sz;
        logic [31:0] data;
        void'($urandom(32'h600c));
        rst   = 1'b1;
        addr  = '0;
        wdata = '0;
        size  = SIZE_WORD;
        rd    = 1'b0;
        we    = 1'b0;
        fence = 1'b0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = initial_byte(i);
        end
        for (int i = 0; i < LINE_COUNT; i++) begin
            res_valid[i] = 1'b0;
            res_dirty[i] = 1'b0;
            res_line[i]  = 0;
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("valid_o", valid, 1'b0);
        check_value("mem_rd_o", mem_rd, 1'b0);
        check_value("mem_we_o", mem_we, 1'b0);
        $display("Test reset done, %0d errors", errors);
        for (int r = 0; r < ROUNDS; r++) begin
            errs_before = errors;
            for (int n = 0; n < OPS; n++) begin
                write = 1'($urandom_range(1, 0));
                a     = $urandom_range(MEM_BYTES - 1, 0);
                sz    = $urandom_range(2, 0);
                data  = $urandom();
                run_access(write, a, sz, data);
            end
            $display("Test random access round %0d done, %0d ops, %0d errors",
                     r, OPS, errors - errs_before);
            errs_before = errors;
            run_fence();
            $display("Test fence %0d done, %0d errors", r, errors - errs_before);
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
